// File: scc_pkg.sv
package scc_pkg;

    ////////////////////
    // data widths
    ////////////////////

    // signed wavetable sample
    localparam int SAMPLE_W     = 8;
    // 32 entries per channel table
    localparam int WAVE_DEPTH_W = 5;
    localparam int FREQ_W       = 12;
    localparam int VOL_W        = 4;
    // signed mixer output
    localparam int SOUND_W      = 11;

    ////////////////////
    // register map
    ////////////////////

    // the map has room for five channels
    localparam int MAX_CH = 5;

    // freq lo/hi pairs start here, two bytes per channel
    localparam logic [7:0] ADDR_FREQ_BASE = 8'h80;
    // one volume byte per channel
    localparam logic [7:0] ADDR_VOL_BASE  = 8'h8A;
    // bit n enables channel n
    localparam logic [7:0] ADDR_MUTE      = 8'h8F;

    // wave space, 00..7F
    typedef struct packed {
        logic                    reg_space;
        logic [1:0]              ch;
        logic [WAVE_DEPTH_W-1:0] idx;
    } wave_view_t;

    // register space, page 8
    typedef struct packed {
        logic [3:0] page;
        logic [3:0] offset;
    } reg_view_t;

    typedef union packed {
        wave_view_t wave;
        reg_view_t  regs;
    } bus_addr_u;

endpackage

// File: scc_bus_decoder.sv
`timescale 1ns/100ps

module scc_bus_decoder #(
    parameter int NUM_CH = 3
) (
    input  logic                                  i_emuclk,
    input  logic                                  i_rst_n,
    input  logic                                  i_wr,
    input  logic                                  i_rd,
    input  logic [7:0]                            i_addr,
    input  logic [7:0]                            i_wdata,
    output logic                                  o_wave_we,
    output logic                                  o_wave_re,
    output logic [scc_pkg::WAVE_DEPTH_W+1:0]      o_wave_addr,
    output logic [scc_pkg::SAMPLE_W-1:0]          o_wave_wdata,
    output logic [NUM_CH*scc_pkg::FREQ_W-1:0]     o_freq,
    output logic [NUM_CH*scc_pkg::VOL_W-1:0]      o_vol,
    output logic [NUM_CH-1:0]                     o_mute_en
);
    import scc_pkg::*;

    bus_addr_u  addr;
    logic       wave_hit;
    logic       reg_wr;
    logic [3:0] freq_off;
    logic [3:0] vol_off;
    logic       freq_hit;
    logic       vol_hit;

    assign addr = i_addr;

    // only populated channel tables respond
    assign wave_hit = !addr.wave.reg_space && (int'(addr.wave.ch) < NUM_CH);

    // every register shares the page of the freq base
    assign reg_wr   = i_wr && (addr.regs.page == ADDR_FREQ_BASE[7:4]);
    assign freq_off = addr.regs.offset - ADDR_FREQ_BASE[3:0];
    assign vol_off  = addr.regs.offset - ADDR_VOL_BASE[3:0];
    assign freq_hit = reg_wr && (int'(freq_off) < 2 * MAX_CH);
    assign vol_hit  = reg_wr && (int'(vol_off) < MAX_CH);

    ////////////////////
    // wavetable access
    ////////////////////

    // write beats read when both strobes come together
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_wave_we <= 1'b0;
            o_wave_re <= 1'b0;
        end else begin
            o_wave_we <= i_wr && wave_hit;
            o_wave_re <= i_rd && !i_wr && wave_hit;
        end
    end

    always_ff @(posedge i_emuclk) begin
        o_wave_addr  <= {addr.wave.ch, addr.wave.idx};
        o_wave_wdata <= i_wdata;
    end

    ////////////////////
    // channel registers
    ////////////////////

    for (genvar n = 0; n < NUM_CH; n++) begin : g_ch
        logic [FREQ_W-1:0] freq_q;
        logic [VOL_W-1:0]  vol_q;

        always_ff @(posedge i_emuclk) begin
            if (!i_rst_n) begin
                freq_q <= '0;
                vol_q  <= '0;
            end else begin
                // low byte at even offset, high nibble at odd
                if (freq_hit && freq_off == 4'(2 * n)) begin
                    freq_q[7:0] <= i_wdata;
                end
                if (freq_hit && freq_off == 4'(2 * n + 1)) begin
                    freq_q[FREQ_W-1:8] <= i_wdata[FREQ_W-9:0];
                end
                if (vol_hit && vol_off == 4'(n)) begin
                    vol_q <= i_wdata[VOL_W-1:0];
                end
            end
        end

        assign o_freq[n*FREQ_W +: FREQ_W] = freq_q;
        assign o_vol[n*VOL_W +: VOL_W]    = vol_q;
    end

    // shared enable bits
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_mute_en <= '0;
        end else if (reg_wr && addr.regs.offset == ADDR_MUTE[3:0]) begin
            o_mute_en <= i_wdata[NUM_CH-1:0];
        end
    end

endmodule

// File: scc_wave_ram.sv
`timescale 1ns/100ps

module scc_wave_ram #(
    parameter int NUM_CH = 3
) (
    input  logic                                      i_emuclk,
    input  logic                                      i_rst_n,
    input  logic                                      i_we,
    input  logic                                      i_re,
    input  logic [scc_pkg::WAVE_DEPTH_W+1:0]          i_addr,
    input  logic [scc_pkg::SAMPLE_W-1:0]              i_wdata,
    input  logic [NUM_CH*scc_pkg::WAVE_DEPTH_W-1:0]   i_tone_idx,
    output logic [scc_pkg::SAMPLE_W-1:0]              o_rdata,
    output logic                                      o_rd_valid,
    output logic [NUM_CH*scc_pkg::SAMPLE_W-1:0]       o_tone_sample
);
    import scc_pkg::*;

    localparam int DEPTH = NUM_CH * (2 ** WAVE_DEPTH_W);

    // channel n owns entries n*32 .. n*32+31
    logic [SAMPLE_W-1:0] mem [DEPTH];

    ////////////////////
    // cpu port
    ////////////////////

    always_ff @(posedge i_emuclk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        if (i_re) begin
            o_rdata <= mem[i_addr];
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_re;
        end
    end

    ////////////////////
    // tone ports
    ////////////////////

    // one registered read per voice, old data on a same-cycle write
    always_ff @(posedge i_emuclk) begin
        for (int n = 0; n < NUM_CH; n++) begin
            o_tone_sample[n*SAMPLE_W +: SAMPLE_W] <=
                mem[n * (2 ** WAVE_DEPTH_W) + int'(i_tone_idx[n*WAVE_DEPTH_W +: WAVE_DEPTH_W])];
        end
    end

endmodule

// File: scc_voice.sv
`timescale 1ns/100ps

module scc_voice (
    input  logic                                    i_emuclk,
    input  logic                                    i_rst_n,
    input  logic [scc_pkg::FREQ_W-1:0]              i_freq,
    input  logic [scc_pkg::VOL_W-1:0]               i_vol,
    input  logic signed [scc_pkg::SAMPLE_W-1:0]     i_sample,
    output logic [scc_pkg::WAVE_DEPTH_W-1:0]        o_idx,
    output logic signed [scc_pkg::SAMPLE_W-1:0]     o_level
);
    import scc_pkg::*;

    logic [FREQ_W-1:0]                  period_cnt;
    logic                               step;
    logic signed [SAMPLE_W+VOL_W:0]     prod;

    ////////////////////
    // period counter
    ////////////////////

    assign step = (period_cnt == '0);

    // reload on zero, so one step every freq+1 clocks
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            period_cnt <= '0;
        end else if (step) begin
            period_cnt <= i_freq;
        end else begin
            period_cnt <= period_cnt - 1'b1;
        end
    end

    // index wraps after entry 31
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_idx <= '0;
        end else if (step) begin
            o_idx <= o_idx + 1'b1;
        end
    end

    ////////////////////
    // volume scaling
    ////////////////////

    // volume is unsigned, keep it positive in the signed multiply
    assign prod = i_sample * $signed({1'b0, i_vol});

    // |prod| <= 1920, so the shifted value fits the sample width
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_level <= '0;
        end else begin
            o_level <= SAMPLE_W'(prod >>> VOL_W);
        end
    end

endmodule

// File: scc_mixer.sv
`timescale 1ns/100ps

module scc_mixer #(
    parameter int NUM_CH = 3
) (
    input  logic                                    i_emuclk,
    input  logic                                    i_rst_n,
    input  logic [NUM_CH*scc_pkg::SAMPLE_W-1:0]     i_level,
    input  logic [NUM_CH-1:0]                       i_mute_en,
    output logic signed [scc_pkg::SOUND_W-1:0]      o_sound
);
    import scc_pkg::*;

    logic signed [SOUND_W-1:0] sum;

    // disabled channels contribute nothing
    always_comb begin
        logic signed [SAMPLE_W-1:0] lvl;
        sum = '0;
        for (int n = 0; n < NUM_CH; n++) begin
            lvl = i_mute_en[n] ? i_level[n*SAMPLE_W +: SAMPLE_W] : '0;
            sum = sum + lvl;
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_sound <= '0;
        end else begin
            o_sound <= sum;
        end
    end

endmodule

// File: scc_player.sv
`timescale 1ns/100ps

module scc_player #(
    parameter int NUM_CH = 3
) (
    input  logic                                i_emuclk,
    input  logic                                i_rst_n,
    input  logic                                i_wr,
    input  logic                                i_rd,
    input  logic [7:0]                          i_addr,
    input  logic [7:0]                          i_wdata,
    output logic [7:0]                          o_rdata,
    output logic                                o_rd_valid,
    output logic signed [scc_pkg::SOUND_W-1:0]  o_sound
);
    import scc_pkg::*;

    logic                               wave_we;
    logic                               wave_re;
    logic [WAVE_DEPTH_W+1:0]            wave_addr;
    logic [SAMPLE_W-1:0]                wave_wdata;
    logic [NUM_CH*FREQ_W-1:0]           freq;
    logic [NUM_CH*VOL_W-1:0]            vol;
    logic [NUM_CH-1:0]                  mute_en;
    logic [NUM_CH*WAVE_DEPTH_W-1:0]     tone_idx;
    logic [NUM_CH*SAMPLE_W-1:0]         tone_sample;
    logic [NUM_CH*SAMPLE_W-1:0]         level;

    scc_bus_decoder #(
        .NUM_CH         (NUM_CH)
    ) u_decoder (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (i_rst_n),
        .i_wr           (i_wr),
        .i_rd           (i_rd),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .o_wave_we      (wave_we),
        .o_wave_re      (wave_re),
        .o_wave_addr    (wave_addr),
        .o_wave_wdata   (wave_wdata),
        .o_freq         (freq),
        .o_vol          (vol),
        .o_mute_en      (mute_en)
    );

    scc_wave_ram #(
        .NUM_CH         (NUM_CH)
    ) u_wave_ram (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (i_rst_n),
        .i_we           (wave_we),
        .i_re           (wave_re),
        .i_addr         (wave_addr),
        .i_wdata        (wave_wdata),
        .i_tone_idx     (tone_idx),
        .o_rdata        (o_rdata),
        .o_rd_valid     (o_rd_valid),
        .o_tone_sample  (tone_sample)
    );

    ////////////////////
    // voices
    ////////////////////

    for (genvar n = 0; n < NUM_CH; n++) begin : g_voice
        scc_voice u_voice (
            .i_emuclk   (i_emuclk),
            .i_rst_n    (i_rst_n),
            .i_freq     (freq[n*FREQ_W +: FREQ_W]),
            .i_vol      (vol[n*VOL_W +: VOL_W]),
            .i_sample   (tone_sample[n*SAMPLE_W +: SAMPLE_W]),
            .o_idx      (tone_idx[n*WAVE_DEPTH_W +: WAVE_DEPTH_W]),
            .o_level    (level[n*SAMPLE_W +: SAMPLE_W])
        );
    end

    scc_mixer #(
        .NUM_CH         (NUM_CH)
    ) u_mixer (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (i_rst_n),
        .i_level        (level),
        .i_mute_en      (mute_en),
        .o_sound        (o_sound)
    );

endmodule

// File: scc_player_sva.sv
`timescale 1ns/100ps

module scc_player_sva #(
    parameter int NUM_CH = 3
) (
    input logic                                 i_emuclk,
    input logic                                 i_rst_n,
    input logic                                 i_wr,
    input logic                                 i_rd,
    input logic [7:0]                           i_addr,
    input logic                                 o_rd_valid,
    input logic signed [scc_pkg::SOUND_W-1:0]   o_sound
);

    logic wave_rd;

    // only reads of populated channel tables answer
    assign wave_rd = i_rd && !i_wr && !i_addr[7] && (int'(i_addr[6:5]) < NUM_CH);

    a_valid_pulse: assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        o_rd_valid |=> !o_rd_valid
    ) else $error("o_rd_valid high for two cycles in a row");

    a_reset_state: assert property (
        @(posedge i_emuclk)
        !i_rst_n |=> (!o_rd_valid && o_sound == '0)
    ) else $error("outputs not cleared after reset");

    // decoder stage then ram stage
    a_read_latency: assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        wave_rd |-> ##2 o_rd_valid
    ) else $error("o_rd_valid missing two cycles after a read strobe");

endmodule

bind scc_player scc_player_sva #(
    .NUM_CH     (NUM_CH)
) u_sva (
    .i_emuclk   (i_emuclk),
    .i_rst_n    (i_rst_n),
    .i_wr       (i_wr),
    .i_rd       (i_rd),
    .i_addr     (i_addr),
    .o_rd_valid (o_rd_valid),
    .o_sound    (o_sound)
);

// File: tb_scc_player.sv
`timescale 1ns/100ps

module tb_scc_player;
    import scc_pkg::*;

    localparam int NUM_CH     = 3;
    localparam int SETTLE_MAX = 32;
    localparam int RD_MAX     = 16;

    // constant-sample rows for the volume test
    localparam int VOL_SAMPLE [5] = '{-128, 100, -37, 127, -20};
    localparam int VOL_LEVEL  [5] = '{15, 7, 9, 1, 3};
    // one constant table per channel for the mixer test
    localparam int MIX_SAMPLE [3] = '{90, -64, 45};
    localparam int MIX_LEVEL  [3] = '{15, 8, 12};
    localparam int STEP_FREQ  [3] = '{5, 12, 261};

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_QUIET, OP_SOUND, OP_STEP, OP_END} op_e;

    typedef struct {
        op_e        op;
        logic [7:0] addr;
        logic [7:0] data;
        int         expected;
    } entry_t;

    logic                      emuclk;
    logic                      rst_n;
    logic                      wr;
    logic                      rd;
    logic [7:0]                addr;
    logic [7:0]                wdata;
    logic [7:0]                rdata;
    logic                      rd_valid;
    logic signed [SOUND_W-1:0] sound;

    entry_t table_q [$];
    string  test_names [$];
    int     checks;
    int     errors;
    int     test_checks;
    int     test_errors;

    scc_player #(
        .NUM_CH     (NUM_CH)
    ) DUT (
        .i_emuclk   (emuclk),
        .i_rst_n    (rst_n),
        .i_wr       (wr),
        .i_rd       (rd),
        .i_addr     (addr),
        .i_wdata    (wdata),
        .o_rdata    (rdata),
        .o_rd_valid (rd_valid),
        .o_sound    (sound)
    );

    initial begin
        emuclk = 1'b0;
        forever #10 emuclk = ~emuclk;
    end

    ////////////////////
    // table building
    ////////////////////

    // voice output for one sample at one volume
    function automatic int scaled_level(int sample, int vol);
        return (sample * vol) >>> 4;
    endfunction

    function automatic logic [7:0] wave_addr(int ch, int idx);
        bus_addr_u a;
        a.wave.reg_space = 1'b0;
        a.wave.ch        = 2'(ch);
        a.wave.idx       = WAVE_DEPTH_W'(idx);
        return a;
    endfunction

    function automatic void add_entry(op_e op, logic [7:0] a, logic [7:0] d, int e);
        entry_t ent;
        ent.op       = op;
        ent.addr     = a;
        ent.data     = d;
        ent.expected = e;
        table_q.push_back(ent);
    endfunction

    function automatic void add_fill(int ch, int sample);
        for (int i = 0; i < 32; i++) begin
            add_entry(OP_WR, wave_addr(ch, i), 8'(sample), 0);
        end
    endfunction

    function automatic void add_freq(int ch, int f);
        add_entry(OP_WR, ADDR_FREQ_BASE + 8'(2 * ch), 8'(f), 0);
        add_entry(OP_WR, ADDR_FREQ_BASE + 8'(2 * ch + 1), 8'(f >> 8), 0);
    endfunction

    function automatic void add_end(string name);
        test_names.push_back(name);
        add_entry(OP_END, 8'h00, 8'h00, test_names.size() - 1);
    endfunction

    function automatic void build_table();
        logic [7:0] written [NUM_CH][32];
        int         sum;
        add_entry(OP_QUIET, 8'h00, 8'd8, 0);
        add_end("reset state");

        for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int i = 0; i < 32; i++) begin
                written[ch][i] = 8'($urandom);
                add_entry(OP_WR, wave_addr(ch, i), written[ch][i], 0);
            end
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int i = 0; i < 32; i++) begin
                add_entry(OP_RD, wave_addr(ch, i), 8'h00, int'(written[ch][i]));
            end
        end
        add_end("wavetable read-back");

        add_entry(OP_WR, ADDR_MUTE, 8'h01, 0);
        for (int r = 0; r < 5; r++) begin
            add_fill(0, VOL_SAMPLE[r]);
            add_entry(OP_WR, ADDR_VOL_BASE, 8'(VOL_LEVEL[r]), 0);
            add_entry(OP_SOUND, 8'h00, 8'h00, scaled_level(VOL_SAMPLE[r], VOL_LEVEL[r]));
        end
        add_end("volume scaling");

        sum = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            add_fill(ch, MIX_SAMPLE[ch]);
            add_entry(OP_WR, ADDR_VOL_BASE + 8'(ch), 8'(MIX_LEVEL[ch]), 0);
            sum += scaled_level(MIX_SAMPLE[ch], MIX_LEVEL[ch]);
        end
        add_entry(OP_WR, ADDR_MUTE, 8'h07, 0);
        add_entry(OP_SOUND, 8'h00, 8'h00, sum);
        // drop channel 1 from the sum
        add_entry(OP_WR, ADDR_MUTE, 8'h05, 0);
        add_entry(OP_SOUND, 8'h00, 8'h00, sum - scaled_level(MIX_SAMPLE[1], MIX_LEVEL[1]));
        add_entry(OP_WR, ADDR_MUTE, 8'h00, 0);
        add_entry(OP_SOUND, 8'h00, 8'h00, 0);
        add_end("mixing and mute");

        add_entry(OP_WR, ADDR_MUTE, 8'h01, 0);
        for (int i = 0; i < 32; i++) begin
            add_entry(OP_WR, wave_addr(0, i), 8'(i * 4), 0);
        end
        add_entry(OP_WR, ADDR_VOL_BASE, 8'd15, 0);
        for (int k = 0; k < 3; k++) begin
            add_freq(0, STEP_FREQ[k]);
            add_entry(OP_STEP, 8'h00, 8'h00, STEP_FREQ[k] + 1);
        end
        add_end("frequency stepping");
    endfunction

    ////////////////////
    // bus and checks
    ////////////////////

    task automatic count_check();
        checks++;
        test_checks++;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        @(posedge emuclk);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge emuclk);
        wr    <= 1'b0;
    endtask

    task automatic check_read(input logic [7:0] a, input logic [7:0] exp);
        int   n;
        logic seen;
        @(posedge emuclk);
        rd   <= 1'b1;
        addr <= a;
        @(posedge emuclk);
        rd   <= 1'b0;
        seen = 1'b0;
        n    = 0;
        count_check();
        while (!seen && n < RD_MAX) begin
            @(negedge emuclk);
            seen = (rd_valid === 1'b1);
            n++;
        end
        if (!seen) begin
            $display("timeout: read of address %h got no o_rd_valid within %0d cycles",
                     a, RD_MAX);
            note_error();
        end else if (rdata !== exp) begin
            $display("ERR t=%0t o_rdata expected %h actual %h", $time, exp, rdata);
            note_error();
        end
    endtask

    // fixed window with no read pulse and a steady output
    task automatic check_quiet(input int cycles, input int exp);
        int   n;
        logic bad;
        bad = 1'b0;
        n   = 0;
        count_check();
        while (!bad && n < cycles) begin
            @(negedge emuclk);
            if (rd_valid !== 1'b0) begin
                $display("ERR t=%0t o_rd_valid expected 0 actual %b", $time, rd_valid);
                bad = 1'b1;
            end else if (sound !== exp) begin
                $display("ERR t=%0t o_sound expected %0d actual %0d", $time, exp, sound);
                bad = 1'b1;
            end
            n++;
        end
        if (bad) begin
            note_error();
        end
    endtask

    task automatic wait_sound(input int exp);
        int   n;
        logic hit;
        hit = 1'b0;
        n   = 0;
        count_check();
        while (!hit && n < SETTLE_MAX) begin
            @(negedge emuclk);
            hit = (sound === exp);
            n++;
        end
        if (!hit) begin
            $display("ERR t=%0t o_sound expected %0d actual %0d", $time, exp, sound);
            note_error();
        end
    endtask

    // cycles until o_sound moves, -1 on timeout; call at a falling edge
    task automatic wait_change(input int limit, output int gap);
        logic signed [SOUND_W-1:0] prev;
        int                        n;
        logic                      moved;
        prev  = sound;
        moved = 1'b0;
        n     = 0;
        while (!moved && n < limit) begin
            @(negedge emuclk);
            n++;
            moved = (sound !== prev);
        end
        gap = moved ? n : -1;
    endtask

    task automatic check_interval(input int exp);
        int gap [4];
        int limit;
        limit = 4 * exp + 16;
        count_check();
        @(negedge emuclk);
        // first two gaps may still span the old period
        for (int k = 0; k < 4; k++) begin
            wait_change(limit, gap[k]);
            if (gap[k] < 0) begin
                $display("timeout: o_sound did not change within %0d cycles", limit);
                note_error();
                return;
            end
        end
        for (int k = 2; k < 4; k++) begin
            if (gap[k] != exp) begin
                $display("ERR t=%0t o_sound step interval expected %0d actual %0d",
                         $time, exp, gap[k]);
                note_error();
            end
        end
    endtask

    task automatic report_test(input int idx);
        $display("test %s done: %0d checks, %0d errors", test_names[idx], test_checks,
                 test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        entry_t ent;
        rst_n       = 1'b0;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = 8'h00;
        wdata       = 8'h00;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        void'($urandom(32'h1e4deca7));
        build_table();

        repeat (3) @(posedge emuclk);
        rst_n <= 1'b1;

        for (int i = 0; i < table_q.size(); i++) begin
            ent = table_q[i];
            case (ent.op)
                OP_WR:    bus_write(ent.addr, ent.data);
                OP_RD:    check_read(ent.addr, 8'(ent.expected));
                OP_QUIET: check_quiet(int'(ent.data), ent.expected);
                OP_SOUND: wait_sound(ent.expected);
                OP_STEP:  check_interval(ent.expected);
                OP_END:   report_test(ent.expected);
                default: begin
                    $display("table entry %0d has an unknown operation", i);
                    note_error();
                end
            endcase
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
scc_pkg.sv
scc_bus_decoder.sv
scc_wave_ram.sv
scc_voice.sv
scc_mixer.sv
scc_player.sv
scc_player_sva.sv
tb_scc_player.sv

// File: Bender.yml
package:
  name: scc_player

sources:
  - scc_pkg.sv
  - scc_bus_decoder.sv
  - scc_wave_ram.sv
  - scc_voice.sv
  - scc_mixer.sv
  - scc_player.sv
  - target: test
    files:
      - scc_player_sva.sv
      - tb_scc_player.sv
